// ==== common/scan_cfg_svh.svh ====
`ifndef SCAN_CFG_SVH
`define SCAN_CFG_SVH

`define SCAN_ROW_BITS      15 // ddr3 row address
`define SCAN_COL8_BITS     7 // column in units of 8-bursts
`define SCAN_RC_BITS       22 // {row, col8}
`define SCAN_FW_BITS       13 // max window width in bursts
`define SCAN_FH_BITS       16 // max frame height in lines
`define SCAN_FRAME_BITS    16 // frame counter
`define SCAN_XFER_BITS     6 // transfer length, 0 -> 64
`define SCAN_CALC_LAT      9 // address pipeline depth

`define SCAN_CMD_BASE      16'h0120 // channel command address
`define SCAN_CMD_MASK      16'h07f0

`define SCAN_REG_MODE      4'h0
`define SCAN_REG_START     4'h2 // range start {row, col8}
`define SCAN_REG_FSIZE     4'h3 // start address step per frame
`define SCAN_REG_FLAST     4'h4 // last frame number in range
`define SCAN_REG_FWIDTH    4'h5 // padded line pitch
`define SCAN_REG_WH        4'h6 // {height, width}
`define SCAN_REG_X0Y0      4'h7 // {top, left}

`define SCAN_MODE_NRESET   0 // channel reset while 0
`define SCAN_MODE_EN       1
`define SCAN_MODE_WRITE    2 // 1 = write to memory
`define SCAN_MODE_RST_FRAME 8
`define SCAN_MODE_SINGLE   9
`define SCAN_MODE_REPEAT   10

`endif

// ==== common/scan_pkg.sv ====
`include "scan_cfg_svh.svh"

package scan_pkg;

    typedef struct packed {
        logic [3:0]  addr; // register offset within channel
        logic [31:0] data;
        logic        valid; // single cycle
    } cmd_wr_t;

    typedef struct packed {
        logic [`SCAN_FW_BITS:0]   full_width; // msb set means max
        logic [`SCAN_FW_BITS:0]   width;
        logic [`SCAN_FH_BITS:0]   height;
        logic [`SCAN_FW_BITS-1:0] x0;
        logic [`SCAN_FH_BITS-1:0] y0;
    } win_cfg_t;

    typedef struct packed {
        logic nreset;
        logic en;
        logic write;
        logic rpt; // keep frame enable on
    } mode_t;

    typedef struct packed {
        logic [2:0]                  bank;
        logic [`SCAN_ROW_BITS-1:0]   row;
        logic [`SCAN_COL8_BITS-1:0]  col;
        logic [`SCAN_XFER_BITS-1:0]  num128; // 0 -> 64 bursts
        logic                        partial; // cut by page end, continued next
    } xfer_desc_t;

    typedef struct packed {
        xfer_desc_t               desc;
        logic                     last_in_row;
        logic                     last_row;
        logic [`SCAN_FW_BITS-1:0] next_x; // x/y after this transfer
        logic [`SCAN_FH_BITS-1:0] next_y;
    } calc_res_t;

endpackage

// ==== hdl/cmd_deser.sv ====
`timescale 1ns/100ps
`include "scan_cfg_svh.svh"

module cmd_deser (
    input  logic              mclk,
    input  logic              mrst,
    input  logic [7:0]        cmd_ad, // AL, AH, D0..D3
    input  logic              cmd_stb, // with the first byte
    output scan_pkg::cmd_wr_t cmd_wr
);
    logic [5:0]  stb_sr; // one bit per received byte
    logic [47:0] byte_sr; // first byte ends up in the low bits
    logic [15:0] cmd_addr;
    logic        addr_hit;

    always_ff @(posedge mclk) begin
        if (mrst) stb_sr <= '0;
        else      stb_sr <= {stb_sr[4:0], cmd_stb};
    end

    always_ff @(posedge mclk) begin
        byte_sr <= {cmd_ad, byte_sr[47:8]}; // sampled only when stb_sr[5] is set
    end

    assign cmd_addr = byte_sr[15:0];
    assign addr_hit = ((cmd_addr ^ `SCAN_CMD_BASE) & `SCAN_CMD_MASK) == 16'h0000;

    assign cmd_wr.addr  = cmd_addr[3:0];
    assign cmd_wr.data  = byte_sr[47:16];
    assign cmd_wr.valid = stb_sr[5] & addr_hit; // cycle after the sixth byte

    // a new command may only begin once the previous six bytes are in
    a_stb_overlap: assert property (@(posedge mclk) disable iff (mrst)
        cmd_stb |-> !(|stb_sr[4:0]));

endmodule

// ==== hdl/scan_regs.sv ====
`timescale 1ns/100ps
`include "scan_cfg_svh.svh"

module scan_regs (
    input  logic                        mclk,
    input  logic                        mrst,
    input  scan_pkg::cmd_wr_t           cmd_wr,
    output scan_pkg::win_cfg_t          win,
    output scan_pkg::mode_t             mode,
    output logic [`SCAN_RC_BITS-1:0]    start_addr,
    output logic [`SCAN_RC_BITS-1:0]    frame_size,
    output logic [`SCAN_FRAME_BITS-1:0] last_frame,
    output logic                        single_pulse,
    output logic                        rst_frame_pulse,
    output logic                        param_wr
);
    logic set_mode;
    logic set_start;
    logic set_fsize;
    logic set_flast;
    logic set_fwidth;
    logic set_wh;
    logic set_x0y0;
    logic lo_zero; // low field all zero, store as max
    logic hi_zero;

    assign set_mode   = cmd_wr.valid && (cmd_wr.addr == `SCAN_REG_MODE);
    assign set_start  = cmd_wr.valid && (cmd_wr.addr == `SCAN_REG_START);
    assign set_fsize  = cmd_wr.valid && (cmd_wr.addr == `SCAN_REG_FSIZE);
    assign set_flast  = cmd_wr.valid && (cmd_wr.addr == `SCAN_REG_FLAST);
    assign set_fwidth = cmd_wr.valid && (cmd_wr.addr == `SCAN_REG_FWIDTH);
    assign set_wh     = cmd_wr.valid && (cmd_wr.addr == `SCAN_REG_WH);
    assign set_x0y0   = cmd_wr.valid && (cmd_wr.addr == `SCAN_REG_X0Y0);
    assign lo_zero    = ~|cmd_wr.data[`SCAN_FW_BITS-1:0];
    assign hi_zero    = ~|cmd_wr.data[31:16];
    assign param_wr   = cmd_wr.valid; // any write invalidates the address pipeline

    always_ff @(posedge mclk) begin
        if (mrst) begin
            mode            <= '0; // nreset low -> channel held in reset
            single_pulse    <= 1'b0;
            rst_frame_pulse <= 1'b0;
            start_addr      <= '0;
            frame_size      <= '0;
            last_frame      <= '0;
            win             <= '0;
        end else begin
            if (set_mode) begin
                mode.nreset <= cmd_wr.data[`SCAN_MODE_NRESET];
                mode.en     <= cmd_wr.data[`SCAN_MODE_EN];
                mode.write  <= cmd_wr.data[`SCAN_MODE_WRITE];
                mode.rpt    <= cmd_wr.data[`SCAN_MODE_REPEAT];
            end
            single_pulse    <= set_mode && cmd_wr.data[`SCAN_MODE_SINGLE];
            rst_frame_pulse <= (set_mode && cmd_wr.data[`SCAN_MODE_RST_FRAME]) ||
                               set_start || set_fsize || set_flast; // range changed
            if (set_start) start_addr <= cmd_wr.data[`SCAN_RC_BITS-1:0];
            if (set_start)      frame_size <= `SCAN_RC_BITS'd1; // default, single frame
            else if (set_fsize) frame_size <= cmd_wr.data[`SCAN_RC_BITS-1:0];
            if (set_flast) last_frame <= cmd_wr.data[`SCAN_FRAME_BITS-1:0];
            if (set_fwidth) win.full_width <= {lo_zero, cmd_wr.data[`SCAN_FW_BITS-1:0]};
            if (set_wh) begin
                win.width  <= {lo_zero, cmd_wr.data[`SCAN_FW_BITS-1:0]};
                win.height <= {hi_zero, cmd_wr.data[31:16]};
            end
            if (set_x0y0) begin
                win.x0 <= cmd_wr.data[`SCAN_FW_BITS-1:0];
                win.y0 <= cmd_wr.data[31:16];
            end
        end
    end

endmodule

// ==== addr/frame_addr_track.sv ====
`timescale 1ns/100ps
`include "scan_cfg_svh.svh"

module frame_addr_track (
    input  logic                        mclk,
    input  logic                        mrst,
    input  logic                        frame_start,
    input  logic                        single_pulse,
    input  logic                        rst_frame_pulse,
    input  logic                        repeat_mode,
    input  logic [`SCAN_RC_BITS-1:0]    start_addr,
    input  logic [`SCAN_RC_BITS-1:0]    frame_size,
    input  logic [`SCAN_FRAME_BITS-1:0] last_frame,
    output logic                        frame_go,
    output logic [`SCAN_RC_BITS-1:0]    frame_start_addr,
    output logic [`SCAN_FRAME_BITS-1:0] frame_number
);
    logic                        frame_en; // next frame_start will be accepted
    logic [2:0]                  fs_r; // accepted frame start delay line
    logic [`SCAN_FRAME_BITS-1:0] frame_cntr; // number of the frame to come
    logic [`SCAN_RC_BITS-1:0]    next_addr;
    logic                        is_last;

    assign is_last  = frame_cntr == last_frame;
    assign frame_go = fs_r[2];

    always_ff @(posedge mclk) begin
        if (mrst) begin
            frame_en     <= 1'b0;
            fs_r         <= '0;
            frame_cntr   <= '0;
            frame_number <= '0;
            next_addr    <= '0;
        end else begin
            if (single_pulse || repeat_mode) frame_en <= 1'b1;
            else if (frame_start)            frame_en <= 1'b0; // single: one frame only
            fs_r <= {fs_r[1:0], frame_start & frame_en};
            if (rst_frame_pulse) begin
                frame_cntr <= '0;
                next_addr  <= start_addr; // back to range start
            end else if (fs_r[1]) begin // frame_start_addr already loaded
                frame_cntr <= is_last ? '0 : frame_cntr + 1'b1;
                next_addr  <= is_last ? start_addr : frame_start_addr + frame_size;
            end
            if (rst_frame_pulse) frame_number <= '0;
            else if (fs_r[0])    frame_number <= frame_cntr;
        end
    end

    always_ff @(posedge mclk) begin
        if (fs_r[0]) frame_start_addr <= next_addr; // stable before frame_go
    end

    a_go_enabled: assert property (@(posedge mclk) disable iff (mrst)
        frame_go |-> $past(frame_en, 3));

endmodule

// ==== addr/line_addr_calc.sv ====
`timescale 1ns/100ps
`include "scan_cfg_svh.svh"

module line_addr_calc (
    input  logic                       mclk,
    input  logic                       mrst,
    input  logic                       recalc, // restart pipeline
    input  logic [`SCAN_FW_BITS-1:0]   cur_x, // relative to window
    input  logic [`SCAN_FH_BITS-1:0]   cur_y,
    input  logic                       continued, // tail of a page-cut transfer
    input  logic [`SCAN_XFER_BITS-1:0] leftover,
    input  scan_pkg::win_cfg_t         win,
    input  logic [`SCAN_RC_BITS-1:0]   frame_start_addr,
    output scan_pkg::calc_res_t        res,
    output logic                       calc_valid
);
    logic [`SCAN_CALC_LAT-1:0]              stage; // one-hot stage enable
    logic [`SCAN_CALC_LAT-1:0]              valid_sr;
    logic [`SCAN_FW_BITS-1:0]               frame_x;
    logic [`SCAN_FH_BITS-1:0]               frame_y;
    logic [`SCAN_FH_BITS:0]                 next_y;
    logic [`SCAN_FW_BITS:0]                 row_left; // bursts to the window edge
    logic [2:0]                             bank;
    logic [`SCAN_FH_BITS-4:0]               y8; // frame_y without bank bits
    logic [`SCAN_FW_BITS:0]                 full_width;
    logic [`SCAN_RC_BITS-1:0]               base_addr;
    logic [`SCAN_FW_BITS+`SCAN_FH_BITS-3:0] mul_full;
    logic [`SCAN_RC_BITS-1:0]               mul_rslt;
    logic [`SCAN_RC_BITS-1:0]               line_addr;
    logic [`SCAN_RC_BITS-1:0]               row_col;
    logic [`SCAN_XFER_BITS:0]               lim_by_xfer; // up to 64
    logic [`SCAN_COL8_BITS:0]               page_left; // up to 128
    logic [`SCAN_XFER_BITS:0]               xfer_len;
    logic                                   page_cut;

    always_ff @(posedge mclk) begin
        if (mrst) begin
            stage    <= '0;
            valid_sr <= '0;
        end else begin
            stage    <= recalc ? `SCAN_CALC_LAT'(1) : stage << 1; // restart drops old run
            valid_sr <= recalc ? '0 : {valid_sr[`SCAN_CALC_LAT-2:0], 1'b1};
        end
    end

    assign calc_valid = valid_sr[`SCAN_CALC_LAT-1];
    assign mul_full   = y8 * full_width;

    always_ff @(posedge mclk) begin
        if (stage[0]) begin
            frame_x  <= cur_x + win.x0;
            frame_y  <= cur_y + win.y0;
            next_y   <= {1'b0, cur_y} + 1'b1;
            row_left <= win.width - {1'b0, cur_x};
        end
        if (stage[1]) begin
            bank        <= frame_y[2:0];
            y8          <= frame_y[`SCAN_FH_BITS-1:3];
            full_width  <= win.full_width;
            base_addr   <= frame_start_addr;
            lim_by_xfer <= (|row_left[`SCAN_FW_BITS:`SCAN_XFER_BITS]) ?
                           7'd64 : row_left[`SCAN_XFER_BITS:0];
        end
        if (stage[2]) mul_rslt  <= mul_full[`SCAN_RC_BITS-1:0]; // top bits dropped
        if (stage[3]) line_addr <= base_addr + mul_rslt;
        if (stage[4]) row_col   <= line_addr + frame_x;
        if (stage[5]) page_left <= 8'd128 - row_col[`SCAN_COL8_BITS-1:0];
        if (stage[6]) begin
            page_cut <= !continued && (page_left < lim_by_xfer);
            if (continued) // starts on a page boundary, page limit cannot bind
                xfer_len <= ({1'b0, leftover} < lim_by_xfer) ? {1'b0, leftover} : lim_by_xfer;
            else
                xfer_len <= (page_left < lim_by_xfer) ? page_left[`SCAN_XFER_BITS:0] : lim_by_xfer;
        end
        if (stage[7]) begin
            res.desc <= '{bank, row_col[`SCAN_RC_BITS-1:`SCAN_COL8_BITS],
                          row_col[`SCAN_COL8_BITS-1:0], xfer_len[`SCAN_XFER_BITS-1:0], page_cut};
            res.last_in_row <= row_left == {7'd0, xfer_len};
            res.last_row    <= next_y == win.height;
        end
        if (stage[8]) begin
            res.next_x <= res.last_in_row ? '0 : cur_x + xfer_len;
            res.next_y <= res.last_in_row ? next_y[`SCAN_FH_BITS-1:0] : cur_y;
        end
    end

endmodule

// ==== hdl/scan_ctrl.sv ====
`timescale 1ns/100ps
`include "scan_cfg_svh.svh"

module scan_ctrl (
    input  logic                       mclk,
    input  logic                       mrst,
    input  scan_pkg::mode_t            mode,
    input  logic                       param_wr,
    input  logic                       frame_go,
    input  scan_pkg::calc_res_t        res,
    input  logic                       calc_valid,
    input  logic                       xfer_grant,
    input  logic                       xfer_done,
    input  logic                       next_page, // buffer page freed/filled
    output logic                       recalc,
    output logic [`SCAN_FW_BITS-1:0]   cur_x,
    output logic [`SCAN_FH_BITS-1:0]   cur_y,
    output logic                       continued,
    output logic [`SCAN_XFER_BITS-1:0] leftover,
    output logic                       xfer_want,
    output logic                       xfer_need,
    output logic                       xfer_start_rd,
    output logic                       xfer_start_wr,
    output scan_pkg::xfer_desc_t       xfer,
    output logic                       xfer_page_rst,
    output logic                       frame_done,
    output logic                       frame_finished
);
    logic       chn_rst;
    logic       chn_en;
    logic       chn_rst_d; // to catch reset release
    logic       busy;
    logic       xfer_start;
    logic       start_full; // start that consumes a whole page
    logic       pre_want;
    logic       last_block; // last transfer of the window started
    logic       done_d;
    logic [2:0] page_cntr; // pages available to the memory side
    logic [2:0] pending; // started, not yet done

    assign chn_rst    = ~mode.nreset;
    assign chn_en     = mode.nreset & mode.en;
    assign xfer_start = xfer_start_rd | xfer_start_wr;
    assign start_full = xfer_start & ~xfer.partial;
    assign recalc     = frame_go | xfer_start | param_wr | (chn_rst_d & ~chn_rst);
    assign pre_want   = chn_en && busy && !xfer_want && !xfer_start && !frame_go &&
                        !param_wr && calc_valid && !last_block && (page_cntr != 3'd0);

    always_ff @(posedge mclk) begin
        if (xfer_grant) xfer <= res.desc; // held until the next start
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            chn_rst_d      <= 1'b0;
            xfer_page_rst  <= 1'b1;
            done_d         <= 1'b0;
            xfer_start_rd  <= 1'b0;
            xfer_start_wr  <= 1'b0;
            xfer_want      <= 1'b0;
            xfer_need      <= 1'b0;
            busy           <= 1'b0;
            page_cntr      <= '0;
            pending        <= '0;
            last_block     <= 1'b0;
            continued      <= 1'b0;
            leftover       <= '0;
            cur_x          <= '0;
            cur_y          <= '0;
            frame_done     <= 1'b0;
            frame_finished <= 1'b0;
        end else begin
            chn_rst_d     <= chn_rst;
            xfer_page_rst <= chn_rst;
            done_d        <= xfer_done;
            xfer_start_rd <= xfer_grant && !chn_rst && !mode.write;
            xfer_start_wr <= xfer_grant && !chn_rst && mode.write;
            if (chn_rst || xfer_grant) xfer_want <= 1'b0;
            else if (pre_want)         xfer_want <= 1'b1;
            if (chn_rst || xfer_grant) xfer_need <= 1'b0;
            else if ((pre_want || xfer_want) && (page_cntr >= 3'd3)) xfer_need <= 1'b1;
            if (chn_rst)         busy <= 1'b0;
            else if (frame_go)   busy <= 1'b1;
            else if (frame_done) busy <= 1'b0;
            if (frame_go)                      page_cntr <= mode.write ? 3'd0 : 3'd4;
            else if (start_full && !next_page) page_cntr <= page_cntr - 1'b1;
            else if (!start_full && next_page) page_cntr <= page_cntr + 1'b1;
            if (chn_rst || !busy)            pending <= '0;
            else if (xfer_start && !xfer_done) pending <= pending + 1'b1;
            else if (!xfer_start && xfer_done) pending <= pending - 1'b1;
            if (chn_rst || !busy)  last_block <= 1'b0;
            else if (xfer_start)   last_block <= res.last_row && res.last_in_row;
            if (chn_rst || frame_go) continued <= 1'b0;
            else if (xfer_start)     continued <= xfer.partial;
            if (xfer_start && xfer.partial) leftover <= 6'd0 - xfer.num128; // 64 - cut length
            if (chn_rst || frame_go) begin
                cur_x <= '0; // each frame begins at window origin
                cur_y <= '0;
            end else if (xfer_start) begin
                cur_x <= res.next_x;
                cur_y <= res.next_y;
            end
            frame_done <= busy && last_block && done_d && (pending == 3'd0);
            if (chn_rst || frame_go) frame_finished <= 1'b0;
            else if (frame_done)     frame_finished <= 1'b1;
        end
    end

    a_start_grant: assert property (@(posedge mclk) disable iff (mrst)
        xfer_start |-> $past(xfer_grant && xfer_want));
    a_pending_underflow: assert property (@(posedge mclk) disable iff (mrst || chn_rst)
        (xfer_done && !xfer_start) |-> (pending != 3'd0));
    a_rd_wr_excl: assert property (@(posedge mclk) disable iff (mrst)
        !(xfer_start_rd && xfer_start_wr));

endmodule

// ==== hdl/scanline_rw.sv ====
`timescale 1ns/100ps
`include "scan_cfg_svh.svh"

module scanline_rw (
    input  logic                        mclk,
    input  logic                        mrst,
    input  logic [7:0]                  cmd_ad,
    input  logic                        cmd_stb,
    input  logic                        frame_start,
    input  logic                        next_page,
    output logic                        xfer_want,
    output logic                        xfer_need,
    input  logic                        xfer_grant,
    output logic                        xfer_start_rd,
    output logic                        xfer_start_wr,
    output logic [2:0]                  xfer_bank,
    output logic [`SCAN_ROW_BITS-1:0]   xfer_row,
    output logic [`SCAN_COL8_BITS-1:0]  xfer_col,
    output logic [`SCAN_XFER_BITS-1:0]  xfer_num128,
    output logic                        xfer_partial,
    input  logic                        xfer_done,
    output logic                        frame_done,
    output logic                        frame_finished,
    output logic [`SCAN_FRAME_BITS-1:0] frame_number,
    output logic                        cmd_wrmem,
    output logic                        xfer_page_rst
);
    scan_pkg::cmd_wr_t           cmd_wr;
    scan_pkg::win_cfg_t          win;
    scan_pkg::mode_t             mode;
    scan_pkg::calc_res_t         res;
    scan_pkg::xfer_desc_t        xfer;
    logic [`SCAN_RC_BITS-1:0]    start_addr;
    logic [`SCAN_RC_BITS-1:0]    frame_size;
    logic [`SCAN_FRAME_BITS-1:0] last_frame;
    logic [`SCAN_RC_BITS-1:0]    frame_start_addr;
    logic [`SCAN_FW_BITS-1:0]    cur_x;
    logic [`SCAN_FH_BITS-1:0]    cur_y;
    logic [`SCAN_XFER_BITS-1:0]  leftover;
    logic                        single_pulse;
    logic                        rst_frame_pulse;
    logic                        param_wr;
    logic                        frame_go;
    logic                        recalc;
    logic                        calc_valid;
    logic                        continued;

    assign xfer_bank    = xfer.bank;
    assign xfer_row     = xfer.row;
    assign xfer_col     = xfer.col;
    assign xfer_num128  = xfer.num128;
    assign xfer_partial = xfer.partial;
    assign cmd_wrmem    = mode.write;

    cmd_deser i_cmd_deser (.mclk, .mrst, .cmd_ad, .cmd_stb, .cmd_wr);

    scan_regs i_scan_regs (.mclk, .mrst, .cmd_wr, .win, .mode, .start_addr, .frame_size,
        .last_frame, .single_pulse, .rst_frame_pulse, .param_wr);

    frame_addr_track i_frame_addr_track (.mclk, .mrst, .frame_start, .single_pulse,
        .rst_frame_pulse, .repeat_mode(mode.rpt), .start_addr, .frame_size, .last_frame,
        .frame_go, .frame_start_addr, .frame_number);

    line_addr_calc i_line_addr_calc (.mclk, .mrst, .recalc, .cur_x, .cur_y, .continued,
        .leftover, .win, .frame_start_addr, .res, .calc_valid);

    scan_ctrl i_scan_ctrl (.mclk, .mrst, .mode, .param_wr, .frame_go, .res, .calc_valid,
        .xfer_grant, .xfer_done, .next_page, .recalc, .cur_x, .cur_y, .continued, .leftover,
        .xfer_want, .xfer_need, .xfer_start_rd, .xfer_start_wr, .xfer, .xfer_page_rst,
        .frame_done, .frame_finished);

endmodule

// ==== tests/scanline_rw_tb.sv ====
`timescale 1ns/100ps
`include "scan_cfg_svh.svh"

module scanline_rw_tb;
    localparam int CLK_PERIOD = 4;
    localparam string TEST_FILE = "tests/scanline_rw_tests.txt";

    logic                        mclk;
    logic                        mrst;
    logic [7:0]                  cmd_ad;
    logic                        cmd_stb;
    logic                        frame_start;
    logic                        next_page;
    logic                        xfer_want;
    logic                        xfer_need;
    logic                        xfer_grant;
    logic                        xfer_start_rd;
    logic                        xfer_start_wr;
    logic [2:0]                  xfer_bank;
    logic [`SCAN_ROW_BITS-1:0]   xfer_row;
    logic [`SCAN_COL8_BITS-1:0]  xfer_col;
    logic [`SCAN_XFER_BITS-1:0]  xfer_num128;
    logic                        xfer_partial;
    logic                        xfer_done;
    logic                        frame_done;
    logic                        frame_finished;
    logic [`SCAN_FRAME_BITS-1:0] frame_number;
    logic                        cmd_wrmem;
    logic                        xfer_page_rst;

    int xfer_total = 0; // expected transfers in the file, sizes the watchdog
    int frames_started = 0;
    int done_cnt = 0; // frame_done pulses seen
    int pages = 0; // model of the buffer page counter
    logic wr_mode = 1'b0; // direction last written to the mode register

    scanline_rw i_scanline_rw (.*);

    initial begin
        mclk = 1'b0;
        forever #(CLK_PERIOD / 2) mclk = ~mclk;
    end

    always @(negedge mclk) begin
        if (!mrst && frame_done) done_cnt++; // sampled mid-cycle
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic tick; // 1 ns after the rising edge
        @(posedge mclk);
        #1;
    endtask

    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        bytes = {data, addr}; // low byte goes out first
        for (int i = 0; i < 6; i++) begin
            cmd_ad  = bytes[8*i +: 8];
            cmd_stb = (i == 0);
            tick;
        end
        cmd_stb = 1'b0;
        repeat (3) tick; // register write and channel reset settle
    endtask

    task automatic run_xfer(input logic [31:0] wr, input logic [31:0] bank,
                            input logic [31:0] row, input logic [31:0] col,
                            input logic [31:0] num, input logic [31:0] part,
                            input logic [31:0] frame);
        int wait_cnt;
        int dly;
        wait_cnt = 0;
        while (!xfer_want) begin
            tick;
            wait_cnt++;
            if (wait_cnt > 2000) stop_on_error("no transfer request from the DUT");
        end
        dly = $urandom % 6; // grant delay
        for (int i = 0; i <= dly; i++) begin
            assert (xfer_want && (xfer_need == (pages >= 3)) &&
                    !xfer_start_rd && !xfer_start_wr)
            else stop_on_error($sformatf("Error: %0t want dropped, need=%b or early start",
                                         $time, xfer_need));
            if (i < dly) tick;
        end
        xfer_grant = 1'b1;
        tick;
        xfer_grant = 1'b0;
        assert ((xfer_start_wr == wr[0]) && (xfer_start_rd == !wr[0]) && !xfer_want &&
                (cmd_wrmem == wr[0]))
        else stop_on_error($sformatf("Error: %0t bad start rd=%b wr=%b want=%b wrmem=%b",
                                     $time, xfer_start_rd, xfer_start_wr, xfer_want, cmd_wrmem));
        assert (xfer_bank == bank[2:0] && xfer_row == row[`SCAN_ROW_BITS-1:0] &&
                xfer_col == col[`SCAN_COL8_BITS-1:0] &&
                xfer_num128 == num[`SCAN_XFER_BITS-1:0] && xfer_partial == part[0] &&
                frame_number == frame[`SCAN_FRAME_BITS-1:0])
        else stop_on_error($sformatf("Error: %0t got %h %h %h %h %b f%0d exp %h %h %h %h %b f%0d",
            $time, xfer_bank, xfer_row, xfer_col, xfer_num128, xfer_partial, frame_number,
            bank[2:0], row[14:0], col[6:0], num[5:0], part[0], frame[15:0]));
        if (!part[0]) pages--; // a whole page taken
        tick;
        assert (!xfer_start_rd && !xfer_start_wr)
        else stop_on_error($sformatf("Error: %0t start strobe longer than one cycle", $time));
        repeat ($urandom % 8) tick; // memory busy
        xfer_done = 1'b1;
        tick;
        xfer_done = 1'b0;
        if (!part[0]) begin // whole page moved
            next_page = 1'b1;
            tick;
            next_page = 1'b0;
            pages++;
        end
    endtask

    task automatic wait_frame_done;
        int wait_cnt;
        wait_cnt = 0;
        while (done_cnt != frames_started) begin
            tick;
            wait_cnt++;
            if (wait_cnt > 2000) stop_on_error("frame_done never came after the last transfer");
        end
        repeat (20) begin
            tick;
            assert (!xfer_want && frame_finished && done_cnt == frames_started)
            else stop_on_error($sformatf("Error: %0t extra request or frame_done, done=%0d",
                                         $time, done_cnt));
        end
    endtask

    initial begin
        wait (xfer_total != 0);
        #(xfer_total * 2000 * CLK_PERIOD);
        $display("watchdog expired before all transfers were checked");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        int fd;
        string line;
        byte kind;
        logic [31:0] f [0:6];
        void'($urandom(32'h1ee8));
        mrst = 1'b1;
        cmd_ad = '0;
        cmd_stb = 1'b0;
        frame_start = 1'b0;
        next_page = 1'b0;
        xfer_grant = 1'b0;
        xfer_done = 1'b0;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) stop_on_error("cannot open the test data file");
        while ($fgets(line, fd)) if (line.getc(0) == "E") xfer_total++;
        $fclose(fd);
        repeat (3) @(posedge mclk);
        #1 mrst = 1'b0;
        repeat (10) begin // idle after reset
            tick;
            assert (!xfer_want && !xfer_need && !xfer_start_rd && !xfer_start_wr &&
                    !frame_done && !frame_finished && xfer_page_rst)
            else stop_on_error($sformatf("Error: %0t outputs not idle after reset", $time));
        end
        fd = $fopen(TEST_FILE, "r");
        while ($fgets(line, fd)) begin
            kind = line.getc(0);
            foreach (f[i]) f[i] = '0;
            if (line.len() > 2)
                void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6]));
            case (kind)
                "C": begin
                    send_cmd(f[0][15:0], f[1]);
                    if (f[0][3:0] == `SCAN_REG_MODE) wr_mode = f[1][`SCAN_MODE_WRITE];
                end
                "K": assert (xfer_page_rst == f[0][0])
                     else stop_on_error($sformatf("Error: %0t xfer_page_rst=%b",
                                                  $time, xfer_page_rst));
                "F": begin
                    assert (frames_started == 0 || frame_finished)
                    else stop_on_error($sformatf("Error: %0t frame_finished low", $time));
                    frame_start = 1'b1;
                    tick;
                    frame_start = 1'b0;
                    frames_started++;
                    pages = wr_mode ? 0 : 4; // reloaded on frame_go
                    repeat (4) tick; // past frame_go
                    assert (!frame_finished)
                    else stop_on_error($sformatf("Error: %0t frame_finished kept", $time));
                end
                "N": begin // write buffer still empty
                    repeat (40) begin
                        tick;
                        assert (!xfer_want)
                        else stop_on_error($sformatf("Error: %0t want without page", $time));
                    end
                    next_page = 1'b1;
                    tick;
                    next_page = 1'b0;
                    pages++;
                end
                "E": run_xfer(f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                "D": wait_frame_done;
                default: ; // comments and blank lines
            endcase
        end
        $fclose(fd);
        if (done_cnt == frames_started && frames_started > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_on_error("frame count does not match the frames started");
        end
    end

endmodule

// ==== tests/scanline_rw_tests.txt ====
# C addr data | K page_rst | F frame start | N idle check then next_page | D wait frame_done
# E wr bank row col num128 partial frame  (all hex)
K 1
C 0125 00000100
C 0126 00030014
C 0127 00060004
C 0122 00001000
C 0120 00000203
K 0
F
E 0 6 0020 04 14 0 0000
E 0 7 0020 04 14 0 0000
E 0 0 0022 04 14 0 0000
D
C 0126 00010028
C 0127 00000070
C 0120 00000203
F
E 0 0 0020 70 10 1 0000
E 0 0 0021 00 18 0 0000
D
C 0126 00010014
C 0127 00060004
C 0120 00000207
F
N
E 1 6 0020 04 14 0 0000
D
C 0122 00002000
C 0123 00000400
C 0124 00000002
C 0120 00000403
F
E 0 6 0040 04 14 0 0000
D
F
E 0 6 0048 04 14 0 0001
D
F
E 0 6 0050 04 14 0 0002
D
F
E 0 6 0040 04 14 0 0000
D

// ==== build.f ====
+incdir+common
common/scan_pkg.sv
hdl/cmd_deser.sv
hdl/scan_regs.sv
addr/frame_addr_track.sv
addr/line_addr_calc.sv
hdl/scan_ctrl.sv
hdl/scanline_rw.sv
tests/scanline_rw_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module scanline_rw_tb -o scanline_rw_sim
./obj_dir/scanline_rw_sim
